//--- build.f
guard_cfg_pkg.sv
guard_axi_pkg.sv
guard_cfg_regs.sv
txn_timer.sv
txn_tracker.sv
guard_fault_ctrl.sv
read_guard_top.sv
tb_read_guard.sv

//--- guard_axi_pkg.sv
`default_nettype none

package guard_axi_pkg;

  // Read channel fields seen by the guard
  typedef logic [3:0]  axi_id_t;
  typedef logic [31:0] axi_addr_t;
  // Burst length minus one, as carried on AR
  typedef logic [7:0]  axi_len_t;

  // Life of one tracked read
  typedef enum logic [1:0] {
    FREE       = 2'd0,
    WAIT_FIRST = 2'd1,
    IN_BURST   = 2'd2
  } slot_state_e;

  // One bit per cause, same layout as the status register
  typedef logic [3:0] fault_cause_t;

  localparam int unsigned CauseFirst    = 0;
  localparam int unsigned CauseStall    = 1;
  localparam int unsigned CauseBurst    = 2;
  localparam int unsigned CauseUnwanted = 3;

endpackage

`default_nettype wire

//--- guard_cfg_pkg.sv
`default_nettype none

package guard_cfg_pkg;

  // Config port address and data
  typedef logic [2:0]  cfg_addr_t;
  typedef logic [31:0] cfg_data_t;

  // Budgets and the counters compared against them
  typedef logic [15:0] budget_t;

  // Register map
  localparam cfg_addr_t RegCtrl        = 3'd0;
  localparam cfg_addr_t RegBudgetFirst = 3'd1;
  localparam cfg_addr_t RegBudgetStall = 3'd2;
  localparam cfg_addr_t RegBudgetBeat  = 3'd3;
  localparam cfg_addr_t RegStatus      = 3'd4;
  localparam cfg_addr_t RegFaultAddr   = 3'd5;

  // Budget values after reset, in clock cycles
  localparam budget_t BudgetFirstRst = 16'd64;
  localparam budget_t BudgetStallRst = 16'd32;
  localparam budget_t BudgetBeatRst  = 16'd16;

endpackage

`default_nettype wire

//--- guard_cfg_regs.sv
`timescale 1ns/1ns
`default_nettype none

module guard_cfg_regs (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        cfg_req_i,
  input  logic                        cfg_we_i,
  input  guard_cfg_pkg::cfg_addr_t    cfg_addr_i,
  input  guard_cfg_pkg::cfg_data_t    cfg_wdata_i,
  output logic                        cfg_ack_o,
  output guard_cfg_pkg::cfg_data_t    cfg_rdata_o,
  input  guard_axi_pkg::fault_cause_t fault_set_i,
  input  guard_axi_pkg::axi_addr_t    fault_addr_i,
  output logic                        enable_o,
  output guard_cfg_pkg::budget_t      budget_first_o,
  output guard_cfg_pkg::budget_t      budget_stall_o,
  output guard_cfg_pkg::budget_t      budget_beat_o,
  output logic                        fault_active_o
);
  import guard_cfg_pkg::*;
  import guard_axi_pkg::*;

  logic         ack_q;
  logic         access;
  logic         wr_en;
  cfg_data_t    rdata_d;
  cfg_data_t    rdata_q;
  logic         enable_q;
  budget_t      budget_first_q;
  budget_t      budget_stall_q;
  budget_t      budget_beat_q;
  fault_cause_t status_q;
  fault_cause_t status_clr;
  axi_addr_t    fault_addr_q;

  // New access only once the previous ack has fallen
  assign access = cfg_req_i && !ack_q;
  assign wr_en  = access && cfg_we_i;

  // Write one to clear
  assign status_clr = (wr_en && cfg_addr_i == RegStatus) ?
                      cfg_wdata_i[$bits(fault_cause_t)-1:0] : '0;

  always_comb begin
    case (cfg_addr_i)
      RegCtrl:        rdata_d = cfg_data_t'(enable_q);
      RegBudgetFirst: rdata_d = cfg_data_t'(budget_first_q);
      RegBudgetStall: rdata_d = cfg_data_t'(budget_stall_q);
      RegBudgetBeat:  rdata_d = cfg_data_t'(budget_beat_q);
      RegStatus:      rdata_d = cfg_data_t'(status_q);
      RegFaultAddr:   rdata_d = cfg_data_t'(fault_addr_q);
      default:        rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q          <= 1'b0;
      rdata_q        <= '0;
      enable_q       <= 1'b0;
      budget_first_q <= BudgetFirstRst;
      budget_stall_q <= BudgetStallRst;
      budget_beat_q  <= BudgetBeatRst;
      status_q       <= '0;
      fault_addr_q   <= '0;
    end else begin
      if (access) begin
        ack_q   <= 1'b1;
        rdata_q <= rdata_d;
      end else if (ack_q && !cfg_req_i) begin
        ack_q <= 1'b0;
      end
      if (wr_en) begin
        case (cfg_addr_i)
          RegCtrl:        enable_q       <= cfg_wdata_i[0];
          RegBudgetFirst: budget_first_q <= cfg_wdata_i[$bits(budget_t)-1:0];
          RegBudgetStall: budget_stall_q <= cfg_wdata_i[$bits(budget_t)-1:0];
          RegBudgetBeat:  budget_beat_q  <= cfg_wdata_i[$bits(budget_t)-1:0];
          default:        ;
        endcase
      end
      // A cause arriving with a clear stays set
      status_q <= (status_q & ~status_clr) | fault_set_i;
      // Only the first fault's address is kept
      if (status_q == '0 && fault_set_i != '0) begin
        fault_addr_q <= fault_addr_i;
      end
    end
  end

  assign cfg_ack_o      = ack_q;
  assign cfg_rdata_o    = rdata_q;
  assign enable_o       = enable_q;
  assign budget_first_o = budget_first_q;
  assign budget_stall_o = budget_stall_q;
  assign budget_beat_o  = budget_beat_q;
  assign fault_active_o = |status_q;

endmodule

`default_nettype wire

//--- guard_fault_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module guard_fault_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic enable_i,
  input  logic fault_active_i,
  input  logic full_i,
  input  logic m_ar_valid_i,
  input  logic s_ar_ready_i,
  input  logic s_r_valid_i,
  input  logic m_r_ready_i,
  output logic m_ar_ready_o,
  output logic s_ar_valid_o,
  output logic m_r_valid_o,
  output logic s_r_ready_o,
  output logic ar_fire_o,
  output logic r_fire_o,
  output logic irq_o,
  output logic reset_req_o
);

  logic block_ar;
  logic block_r;
  logic fault_q;

  // Disabled guard passes everything through
  assign block_ar = enable_i && (fault_active_i || full_i);
  assign block_r  = enable_i && fault_active_i;

  assign m_ar_ready_o = s_ar_ready_i && !block_ar;
  assign s_ar_valid_o = m_ar_valid_i && !block_ar;
  assign m_r_valid_o  = s_r_valid_i && !block_r;
  assign s_r_ready_o  = m_r_ready_i && !block_r;

  // Handshakes as seen after gating
  assign ar_fire_o = s_ar_valid_o && s_ar_ready_i;
  assign r_fire_o  = m_r_valid_o && m_r_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fault_q <= 1'b0;
    end else begin
      fault_q <= enable_i && fault_active_i;
    end
  end

  assign irq_o       = fault_q;
  assign reset_req_o = fault_q;

endmodule

`default_nettype wire

//--- read_guard_top.sv
`timescale 1ns/1ns
`default_nettype none

module read_guard_top #(
  parameter int unsigned MaxTxns = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Master side
  input  logic                     m_ar_valid_i,
  input  guard_axi_pkg::axi_id_t   m_ar_id_i,
  input  guard_axi_pkg::axi_addr_t m_ar_addr_i,
  input  guard_axi_pkg::axi_len_t  m_ar_len_i,
  output logic                     m_ar_ready_o,
  output logic                     m_r_valid_o,
  output guard_axi_pkg::axi_id_t   m_r_id_o,
  output logic                     m_r_last_o,
  input  logic                     m_r_ready_i,
  // Slave side
  output logic                     s_ar_valid_o,
  output guard_axi_pkg::axi_id_t   s_ar_id_o,
  output guard_axi_pkg::axi_addr_t s_ar_addr_o,
  output guard_axi_pkg::axi_len_t  s_ar_len_o,
  input  logic                     s_ar_ready_i,
  input  logic                     s_r_valid_i,
  input  guard_axi_pkg::axi_id_t   s_r_id_i,
  input  logic                     s_r_last_i,
  output logic                     s_r_ready_o,
  // Config port
  input  logic                     cfg_req_i,
  input  logic                     cfg_we_i,
  input  guard_cfg_pkg::cfg_addr_t cfg_addr_i,
  input  guard_cfg_pkg::cfg_data_t cfg_wdata_i,
  output logic                     cfg_ack_o,
  output guard_cfg_pkg::cfg_data_t cfg_rdata_o,
  output logic                     irq_o,
  output logic                     reset_req_o
);
  import guard_axi_pkg::*;
  import guard_cfg_pkg::*;

  logic         enable;
  logic         fault_active;
  logic         full;
  logic         ar_fire;
  logic         r_fire;
  budget_t      budget_first;
  budget_t      budget_stall;
  budget_t      budget_beat;
  fault_cause_t fault_set;
  axi_addr_t    fault_addr;

  // Payload fields are never gated
  assign s_ar_id_o   = m_ar_id_i;
  assign s_ar_addr_o = m_ar_addr_i;
  assign s_ar_len_o  = m_ar_len_i;
  assign m_r_id_o    = s_r_id_i;
  assign m_r_last_o  = s_r_last_i;

  guard_cfg_regs regs_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cfg_req_i      (cfg_req_i),
    .cfg_we_i       (cfg_we_i),
    .cfg_addr_i     (cfg_addr_i),
    .cfg_wdata_i    (cfg_wdata_i),
    .cfg_ack_o      (cfg_ack_o),
    .cfg_rdata_o    (cfg_rdata_o),
    .fault_set_i    (fault_set),
    .fault_addr_i   (fault_addr),
    .enable_o       (enable),
    .budget_first_o (budget_first),
    .budget_stall_o (budget_stall),
    .budget_beat_o  (budget_beat),
    .fault_active_o (fault_active)
  );

  txn_tracker #(
    .MaxTxns (MaxTxns)
  ) tracker_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .enable_i       (enable),
    .ar_fire_i      (ar_fire),
    .ar_id_i        (m_ar_id_i),
    .ar_addr_i      (m_ar_addr_i),
    .ar_len_i       (m_ar_len_i),
    .r_fire_i       (r_fire),
    .r_valid_i      (m_r_valid_o),
    .r_ready_i      (s_r_ready_o),
    .r_id_i         (s_r_id_i),
    .r_last_i       (s_r_last_i),
    .budget_first_i (budget_first),
    .budget_stall_i (budget_stall),
    .budget_beat_i  (budget_beat),
    .full_o         (full),
    .fault_set_o    (fault_set),
    .fault_addr_o   (fault_addr)
  );

  guard_fault_ctrl fault_ctrl_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .enable_i       (enable),
    .fault_active_i (fault_active),
    .full_i         (full),
    .m_ar_valid_i   (m_ar_valid_i),
    .s_ar_ready_i   (s_ar_ready_i),
    .s_r_valid_i    (s_r_valid_i),
    .m_r_ready_i    (m_r_ready_i),
    .m_ar_ready_o   (m_ar_ready_o),
    .s_ar_valid_o   (s_ar_valid_o),
    .m_r_valid_o    (m_r_valid_o),
    .s_r_ready_o    (s_r_ready_o),
    .ar_fire_o      (ar_fire),
    .r_fire_o       (r_fire),
    .irq_o          (irq_o),
    .reset_req_o    (reset_req_o)
  );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the read guard testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_read_guard -f build.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_read_guard > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- tb_read_guard.sv
`timescale 1ns/1ns
`default_nettype none

module tb_read_guard;

  localparam int unsigned MaxTxns = 4;
  // Upper bound on any single handshake wait, in cycles
  localparam int unsigned HsLimit = 200;
  // First-data delay value for a slave that never answers
  localparam logic [15:0] NoData = 16'hFFFF;

  localparam logic [2:0] AddrCtrl        = 3'd0;
  localparam logic [2:0] AddrBudgetFirst = 3'd1;
  localparam logic [2:0] AddrBudgetStall = 3'd2;
  localparam logic [2:0] AddrBudgetBeat  = 3'd3;
  localparam logic [2:0] AddrStatus      = 3'd4;
  localparam logic [2:0] AddrFaultAddr   = 3'd5;

  localparam logic [3:0] FaultNone     = 4'b0000;
  localparam logic [3:0] FaultFirst    = 4'b0001;
  localparam logic [3:0] FaultStall    = 4'b0010;
  localparam logic [3:0] FaultBurst    = 4'b0100;
  localparam logic [3:0] FaultUnwanted = 4'b1000;

  // One read scenario with its budgets and the cause it should raise
  typedef struct packed {
    logic [15:0] budget_first;
    logic [15:0] budget_stall;
    logic [15:0] budget_beat;
    logic [3:0]  id;
    logic [7:0]  len;
    logic [15:0] first_delay;
    logic [15:0] stall;
    logic [3:0]  cause;
  } row_t;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        m_ar_valid_i;
  logic [3:0]  m_ar_id_i;
  logic [31:0] m_ar_addr_i;
  logic [7:0]  m_ar_len_i;
  logic        m_ar_ready_o;
  logic        m_r_valid_o;
  logic [3:0]  m_r_id_o;
  logic        m_r_last_o;
  logic        m_r_ready_i;
  logic        s_ar_valid_o;
  logic [3:0]  s_ar_id_o;
  logic [31:0] s_ar_addr_o;
  logic [7:0]  s_ar_len_o;
  logic        s_ar_ready_i;
  logic        s_r_valid_i;
  logic [3:0]  s_r_id_i;
  logic        s_r_last_i;
  logic        s_r_ready_o;
  logic        cfg_req_i;
  logic        cfg_we_i;
  logic [2:0]  cfg_addr_i;
  logic [31:0] cfg_wdata_i;
  logic        cfg_ack_o;
  logic [31:0] cfg_rdata_o;
  logic        irq_o;
  logic        reset_req_o;

  row_t        rows[$];
  logic [31:0] rng_state = 32'd58470;
  int unsigned watchdog_cycles = 0;
  int unsigned checks = 0;
  int unsigned errors = 0;
  int unsigned failures = 0;

  read_guard_top #(
    .MaxTxns (MaxTxns)
  ) dut_i (.*);

  always #5 clk_i = ~clk_i;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    failures++;
    $display("Failure at %0t ns: %s", $time, what);
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic void add_row(input logic [15:0] bf, input logic [15:0] bs,
                                  input logic [15:0] bb, input logic [3:0] id,
                                  input logic [7:0] len, input logic [15:0] delay,
                                  input logic [15:0] stall, input logic [3:0] cause);
    row_t r;
    r.budget_first = bf;
    r.budget_stall = bs;
    r.budget_beat  = bb;
    r.id           = id;
    r.len          = len;
    r.first_delay  = delay;
    r.stall        = stall;
    r.cause        = cause;
    rows.push_back(r);
  endfunction

  // Four-phase access, entered and left on a falling edge
  task automatic reg_access(input logic we, input logic [2:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int unsigned n;
    n = 0;
    rdata = '0;
    cfg_we_i = we;
    cfg_addr_i = addr;
    cfg_wdata_i = wdata;
    cfg_req_i = 1'b1;
    do begin
      @(negedge clk_i);
      n++;
    end while (!cfg_ack_o && n < HsLimit);
    if (!cfg_ack_o) report_failure("config port never raised ack");
    rdata = cfg_rdata_o;
    cfg_req_i = 1'b0;
    n = 0;
    while (cfg_ack_o && n < HsLimit) begin
      @(negedge clk_i);
      n++;
    end
    if (cfg_ack_o) report_failure("config port never dropped ack");
  endtask

  task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    reg_access(1'b1, addr, data, unused);
  endtask

  task automatic expect_reg(input string name, input logic [2:0] addr,
                            input logic [31:0] exp);
    logic [31:0] data;
    reg_access(1'b0, addr, 32'd0, data);
    check_value(name, data, exp);
  endtask

  task automatic wait_ar_accept(input logic [3:0] id, input logic [31:0] addr,
                                input logic [7:0] len);
    int unsigned n;
    logic        ok;
    n = 0;
    ok = 1'b0;
    while (!ok && n < HsLimit) begin
      #1;
      if (m_ar_ready_o) begin
        ok = 1'b1;
        // Slave side sees the same request in the accepting cycle
        check_value("s_ar_valid_o", 32'(s_ar_valid_o), 32'd1);
        check_value("s_ar_id_o", 32'(s_ar_id_o), 32'(id));
        check_value("s_ar_addr_o", s_ar_addr_o, addr);
        check_value("s_ar_len_o", 32'(s_ar_len_o), 32'(len));
      end
      @(negedge clk_i);
      n++;
    end
    m_ar_valid_i = 1'b0;
    if (!ok) report_failure("read address was never accepted");
  endtask

  task automatic issue_read(input logic [3:0] id, input logic [31:0] addr,
                            input logic [7:0] len);
    m_ar_valid_i = 1'b1;
    m_ar_id_i = id;
    m_ar_addr_i = addr;
    m_ar_len_i = len;
    wait_ar_accept(id, addr, len);
  endtask

  task automatic watch_idle(input int unsigned cycles, output logic fault_seen);
    int unsigned n;
    n = 0;
    fault_seen = 1'b0;
    while (n < cycles && !fault_seen) begin
      #1;
      if (irq_o) fault_seen = 1'b1;
      @(negedge clk_i);
      n++;
    end
  endtask

  task automatic wait_irq(input int unsigned limit, output int unsigned cycles);
    int unsigned n;
    logic        found;
    n = 0;
    found = 1'b0;
    cycles = limit;
    while (!found && n < limit) begin
      #1;
      if (irq_o) begin
        found = 1'b1;
        cycles = n;
      end
      @(negedge clk_i);
      n++;
    end
    if (!found) report_failure("irq_o did not rise after a fault");
  endtask

  // Slave returns the burst while the master holds r_ready low for stall cycles per beat
  task automatic send_beats(input logic [3:0] id, input logic [7:0] len,
                            input logic [15:0] stall, output logic fault_seen);
    int unsigned c;
    logic        done;
    logic        stop;
    fault_seen = 1'b0;
    stop = 1'b0;
    for (int b = 0; b <= int'(len) && !fault_seen && !stop; b++) begin
      s_r_valid_i = 1'b1;
      s_r_id_i    = id;
      s_r_last_i  = (b == int'(len));
      m_r_ready_i = 1'b0;
      c = 0;
      done = 1'b0;
      while (!done && !fault_seen && !stop) begin
        if (c >= 32'(stall)) m_r_ready_i = 1'b1;
        #1;
        if (irq_o) begin
          fault_seen = 1'b1;
        end else if (m_r_valid_o && m_r_ready_i) begin
          done = 1'b1;
          check_value("m_r_id_o", 32'(m_r_id_o), 32'(id));
          check_value("m_r_last_o", 32'(m_r_last_o), 32'(b == int'(len)));
          check_value("s_r_ready_o", 32'(s_r_ready_o), 32'd1);
        end else if (c > 32'(stall) + HsLimit) begin
          report_failure("R beat was never accepted");
          stop = 1'b1;
        end
        @(negedge clk_i);
        c++;
      end
    end
    s_r_valid_i = 1'b0;
    s_r_last_i  = 1'b0;
    m_r_ready_i = 1'b0;
  endtask

  task automatic clear_fault();
    write_reg(AddrStatus, 32'hF);
    check_value("irq_o after clear", 32'(irq_o), 32'd0);
    check_value("reset_req_o after clear", 32'(reset_req_o), 32'd0);
    expect_reg("status after clear", AddrStatus, 32'd0);
  endtask

  task automatic run_row(input row_t r);
    logic [31:0] addr;
    logic        fault_seen;
    int unsigned cycles;
    write_reg(AddrBudgetFirst, 32'(r.budget_first));
    write_reg(AddrBudgetStall, 32'(r.budget_stall));
    write_reg(AddrBudgetBeat, 32'(r.budget_beat));
    rng_state = lcg_next(rng_state);
    addr = {rng_state[31:2], 2'b00};
    issue_read(r.id, addr, r.len);
    fault_seen = 1'b0;
    if (r.first_delay == NoData) begin
      wait_irq(32'(r.budget_first) + 16, cycles);
      check_value("irq_o within first-data budget plus 4",
                  32'(cycles <= 32'(r.budget_first) + 4), 32'd1);
    end else begin
      watch_idle(32'(r.first_delay), fault_seen);
      if (!fault_seen) send_beats(r.id, r.len, r.stall, fault_seen);
    end
    repeat (3) @(negedge clk_i);
    check_value("irq_o", 32'(irq_o), 32'(r.cause != FaultNone));
    check_value("reset_req_o", 32'(reset_req_o), 32'(r.cause != FaultNone));
    expect_reg("status", AddrStatus, 32'(r.cause));
    if (r.cause != FaultNone) begin
      expect_reg("fault address", AddrFaultAddr, addr);
      check_value("m_ar_ready_o during fault", 32'(m_ar_ready_o), 32'd0);
      clear_fault();
    end
  endtask

  task automatic stray_beat(input logic [3:0] id);
    s_r_valid_i = 1'b1;
    s_r_id_i    = id;
    s_r_last_i  = 1'b1;
    m_r_ready_i = 1'b1;
    #1;
    check_value("m_r_valid_o for stray beat", 32'(m_r_valid_o), 32'd1);
    check_value("m_r_id_o for stray beat", 32'(m_r_id_o), 32'(id));
    @(negedge clk_i);
    s_r_valid_i = 1'b0;
    s_r_last_i  = 1'b0;
    m_r_ready_i = 1'b0;
  endtask

  task automatic check_unwanted_beat();
    int unsigned cycles;
    stray_beat(4'd9);
    wait_irq(8, cycles);
    check_value("reset_req_o on stray beat", 32'(reset_req_o), 32'd1);
    expect_reg("status on stray beat", AddrStatus, 32'(FaultUnwanted));
    clear_fault();
    // Disabled guard forwards the beat and tracks nothing
    write_reg(AddrCtrl, 32'd0);
    stray_beat(4'd9);
    repeat (4) @(negedge clk_i);
    check_value("irq_o while disabled", 32'(irq_o), 32'd0);
    expect_reg("status while disabled", AddrStatus, 32'd0);
    write_reg(AddrCtrl, 32'd1);
  endtask

  task automatic check_table_full();
    logic fault_seen;
    write_reg(AddrBudgetFirst, 32'd500);
    for (int k = 0; k < int'(MaxTxns); k++) begin
      rng_state = lcg_next(rng_state);
      issue_read(4'(k), rng_state, 8'd0);
    end
    rng_state = lcg_next(rng_state);
    m_ar_valid_i = 1'b1;
    m_ar_id_i = 4'(MaxTxns);
    m_ar_addr_i = rng_state;
    m_ar_len_i = 8'd0;
    repeat (6) begin
      #1;
      check_value("m_ar_ready_o with full table", 32'(m_ar_ready_o), 32'd0);
      check_value("s_ar_valid_o with full table", 32'(s_ar_valid_o), 32'd0);
      @(negedge clk_i);
    end
    // Completing the oldest read frees a slot for the waiting one
    send_beats(4'd0, 8'd0, 16'd0, fault_seen);
    wait_ar_accept(4'(MaxTxns), rng_state, 8'd0);
    for (int k = 1; k <= int'(MaxTxns); k++) begin
      send_beats(4'(k), 8'd0, 16'd0, fault_seen);
    end
    repeat (2) @(negedge clk_i);
    check_value("irq_o after full table", 32'(irq_o), 32'd0);
    expect_reg("status after full table", AddrStatus, 32'd0);
  endtask

  initial begin
    int unsigned budget_sum;
    rst_ni = 1'b0;
    m_ar_valid_i = 1'b0;
    m_ar_id_i = '0;
    m_ar_addr_i = '0;
    m_ar_len_i = '0;
    m_r_ready_i = 1'b0;
    s_ar_ready_i = 1'b0;
    s_r_valid_i = 1'b0;
    s_r_id_i = '0;
    s_r_last_i = 1'b0;
    cfg_req_i = 1'b0;
    cfg_we_i = 1'b0;
    cfg_addr_i = '0;
    cfg_wdata_i = '0;

    // first, stall, beat budgets | id, len, first delay, stall per beat | cause
    add_row(16'd40, 16'd20, 16'd16, 4'd1, 8'd3, 16'd5, 16'd3, FaultNone);
    add_row(16'd64, 16'd32, 16'd16, 4'd2, 8'd0, 16'd10, 16'd0, FaultNone);
    add_row(16'd30, 16'd20, 16'd16, 4'd3, 8'd1, NoData, 16'd0, FaultFirst);
    add_row(16'd100, 16'd4, 16'd50, 4'd4, 8'd1, 16'd2, 16'd8, FaultStall);
    add_row(16'd100, 16'd10, 16'd2, 4'd5, 8'd3, 16'd2, 16'd4, FaultBurst);
    add_row(16'd40, 16'd20, 16'd16, 4'd6, 8'd7, 16'd3, 16'd1, FaultNone);

    budget_sum = 0;
    for (int k = 0; k < rows.size(); k++) begin
      budget_sum += 32'(rows[k].budget_first) + 32'(rows[k].budget_stall);
      budget_sum += 32'(rows[k].budget_beat) * (32'(rows[k].len) + 1);
      budget_sum += (32'(rows[k].len) + 1) * (32'(rows[k].stall) + 1) + 60;
      if (rows[k].first_delay != NoData) budget_sum += 32'(rows[k].first_delay);
    end
    watchdog_cycles = budget_sum + 3000;

    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    s_ar_ready_i = 1'b1;

    expect_reg("ctrl after reset", AddrCtrl, 32'd0);
    expect_reg("first budget after reset", AddrBudgetFirst, 32'd64);
    expect_reg("stall budget after reset", AddrBudgetStall, 32'd32);
    expect_reg("beat budget after reset", AddrBudgetBeat, 32'd16);
    expect_reg("status after reset", AddrStatus, 32'd0);
    check_value("irq_o after reset", 32'(irq_o), 32'd0);
    write_reg(AddrBudgetFirst, 32'd123);
    expect_reg("first budget readback", AddrBudgetFirst, 32'd123);
    write_reg(AddrBudgetStall, 32'd45);
    expect_reg("stall budget readback", AddrBudgetStall, 32'd45);
    write_reg(AddrBudgetBeat, 32'd7);
    expect_reg("beat budget readback", AddrBudgetBeat, 32'd7);
    write_reg(AddrCtrl, 32'd1);
    expect_reg("ctrl readback", AddrCtrl, 32'd1);

    for (int k = 0; k < rows.size(); k++) begin
      run_row(rows[k]);
    end
    check_unwanted_beat();
    check_table_full();

    $display("Checks run: %0d, value errors: %0d, other failures: %0d",
             checks, errors, failures);
    if (errors == 0 && failures == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    wait (watchdog_cycles != 0);
    repeat (watchdog_cycles) @(posedge clk_i);
    $display("Simulation did not finish within %0d cycles", watchdog_cycles);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- txn_timer.sv
`timescale 1ns/1ns
`default_nettype none

module txn_timer (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        alloc_i,
  input  logic                        free_i,
  input  logic                        beat_i,
  input  logic                        stall_i,
  input  guard_axi_pkg::axi_len_t     len_i,
  input  guard_cfg_pkg::budget_t      budget_first_i,
  input  guard_cfg_pkg::budget_t      budget_stall_i,
  input  guard_cfg_pkg::budget_t      budget_beat_i,
  output guard_axi_pkg::slot_state_e  state_o,
  output guard_axi_pkg::fault_cause_t timeout_o
);
  import guard_axi_pkg::*;
  import guard_cfg_pkg::*;

  localparam int unsigned LimitWidth = $bits(budget_t) + $bits(axi_len_t) + 1;

  slot_state_e           state_q;
  budget_t               wait_cnt_q;
  budget_t               stall_cnt_q;
  budget_t               burst_cnt_q;
  logic [LimitWidth-1:0] burst_limit;

  // Per-beat budget times the number of beats
  assign burst_limit = LimitWidth'(budget_beat_i) * (LimitWidth'(len_i) + 1'b1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FREE;
      wait_cnt_q  <= '0;
      stall_cnt_q <= '0;
      burst_cnt_q <= '0;
    end else begin
      case (state_q)
        FREE: begin
          if (alloc_i) state_q <= WAIT_FIRST;
        end
        WAIT_FIRST: begin
          if (free_i) begin
            state_q <= FREE;
          end else if (beat_i) begin
            state_q <= IN_BURST;
          end
        end
        IN_BURST: begin
          if (free_i) state_q <= FREE;
        end
        default: state_q <= FREE;
      endcase
      if (alloc_i) begin
        wait_cnt_q  <= '0;
        stall_cnt_q <= '0;
        burst_cnt_q <= '0;
      end else begin
        // Counters saturate instead of wrapping
        if (state_q == WAIT_FIRST && wait_cnt_q != '1) begin
          wait_cnt_q <= wait_cnt_q + 1'b1;
        end
        if (beat_i) begin
          stall_cnt_q <= '0;
        end else if (stall_i && stall_cnt_q != '1) begin
          stall_cnt_q <= stall_cnt_q + 1'b1;
        end
        if (state_q == IN_BURST && burst_cnt_q != '1) begin
          burst_cnt_q <= burst_cnt_q + 1'b1;
        end
      end
    end
  end

  always_comb begin
    timeout_o             = '0;
    timeout_o[CauseFirst] = (state_q == WAIT_FIRST) && (wait_cnt_q == budget_first_i);
    timeout_o[CauseStall] = (state_q != FREE) && stall_i && (stall_cnt_q == budget_stall_i);
    timeout_o[CauseBurst] = (state_q == IN_BURST) &&
                            (LimitWidth'(burst_cnt_q) == burst_limit);
  end

  assign state_o = state_q;

endmodule

`default_nettype wire

//--- txn_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module txn_tracker #(
  parameter int unsigned MaxTxns = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        enable_i,
  input  logic                        ar_fire_i,
  input  guard_axi_pkg::axi_id_t      ar_id_i,
  input  guard_axi_pkg::axi_addr_t    ar_addr_i,
  input  guard_axi_pkg::axi_len_t     ar_len_i,
  input  logic                        r_fire_i,
  input  logic                        r_valid_i,
  input  logic                        r_ready_i,
  input  guard_axi_pkg::axi_id_t      r_id_i,
  input  logic                        r_last_i,
  input  guard_cfg_pkg::budget_t      budget_first_i,
  input  guard_cfg_pkg::budget_t      budget_stall_i,
  input  guard_cfg_pkg::budget_t      budget_beat_i,
  output logic                        full_o,
  output guard_axi_pkg::fault_cause_t fault_set_o,
  output guard_axi_pkg::axi_addr_t    fault_addr_o
);
  import guard_axi_pkg::*;

  localparam int unsigned OrdWidth = (MaxTxns > 1) ? $clog2(MaxTxns) : 1;

  // Number of older same-ID reads still outstanding
  typedef logic [OrdWidth-1:0] ord_t;

  axi_id_t      id_q    [MaxTxns];
  axi_addr_t    addr_q  [MaxTxns];
  axi_len_t     len_q   [MaxTxns];
  ord_t         ord_q   [MaxTxns];
  ord_t         dec     [MaxTxns];
  slot_state_e  state   [MaxTxns];
  fault_cause_t timeout [MaxTxns];

  logic [MaxTxns-1:0] busy;
  logic [MaxTxns-1:0] alloc;
  logic [MaxTxns-1:0] hit;
  logic [MaxTxns-1:0] beat;
  logic [MaxTxns-1:0] stall;
  logic [MaxTxns-1:0] release_slot;
  ord_t               new_ord;
  logic               unwanted;

  assign full_o = &busy;

  // Lowest free slot takes the new read
  always_comb begin
    alloc = '0;
    for (int i = MaxTxns - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        alloc    = '0;
        alloc[i] = ar_fire_i && enable_i;
      end
    end
  end

  // Same-ID reads that stay past this cycle are older than the new one
  always_comb begin
    new_ord = '0;
    for (int j = 0; j < MaxTxns; j++) begin
      if (busy[j] && !release_slot[j] && id_q[j] == ar_id_i) begin
        new_ord = new_ord + 1'b1;
      end
    end
  end

  // A slot moves up once per older same-ID read that leaves
  always_comb begin
    for (int i = 0; i < MaxTxns; i++) begin
      dec[i] = '0;
      for (int j = 0; j < MaxTxns; j++) begin
        if (release_slot[j] && busy[i] && id_q[j] == id_q[i] && ord_q[j] < ord_q[i]) begin
          dec[i] = dec[i] + 1'b1;
        end
      end
    end
  end

  for (genvar i = 0; i < MaxTxns; i++) begin : gen_slot
    assign busy[i]  = (state[i] != FREE);
    // Only the oldest read of an ID may take a beat
    assign hit[i]   = busy[i] && (id_q[i] == r_id_i) && (ord_q[i] == '0);
    assign beat[i]  = r_fire_i && hit[i];
    assign stall[i] = r_valid_i && !r_ready_i && hit[i];
    assign release_slot[i] = busy[i] &&
                             (!enable_i || (beat[i] && r_last_i) || (timeout[i] != '0));

    always_ff @(posedge clk_i) begin
      if (alloc[i]) begin
        id_q[i]   <= ar_id_i;
        addr_q[i] <= ar_addr_i;
        len_q[i]  <= ar_len_i;
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        ord_q[i] <= '0;
      end else if (alloc[i]) begin
        ord_q[i] <= new_ord;
      end else if (busy[i]) begin
        ord_q[i] <= ord_q[i] - dec[i];
      end
    end

    txn_timer timer_i (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .alloc_i        (alloc[i]),
      .free_i         (release_slot[i]),
      .beat_i         (beat[i]),
      .stall_i        (stall[i]),
      .len_i          (len_q[i]),
      .budget_first_i (budget_first_i),
      .budget_stall_i (budget_stall_i),
      .budget_beat_i  (budget_beat_i),
      .state_o        (state[i]),
      .timeout_o      (timeout[i])
    );
  end

  assign unwanted = enable_i && r_fire_i && !(|hit);

  // Lowest timed-out slot reports its address
  always_comb begin
    fault_set_o  = '0;
    fault_addr_o = '0;
    for (int i = MaxTxns - 1; i >= 0; i--) begin
      if (enable_i && timeout[i] != '0) begin
        fault_set_o  = fault_set_o | timeout[i];
        fault_addr_o = addr_q[i];
      end
    end
    fault_set_o[CauseUnwanted] = unwanted;
  end

endmodule

`default_nettype wire
